//--- Makefile
# Verilator build and run for the tile store testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_tile_store
RTL_TOP    ?= tile_store_top
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
rtl/store_pkg.sv
rtl/beat_fifo_if.sv
rtl/tile_waddr_gen.sv
rtl/beat_fifo.sv
rtl/tile_wdata_drain.sv
rtl/tile_store_top.sv
tb/tile_store_asserts.sv
tb/tb_tile_store.sv

//--- rtl/beat_fifo.sv
// Synchronous first-word-fall-through FIFO for data beats.
// The oldest beat sits on pop_data whenever empty is low. Pushes while
// full are dropped.

`timescale 1ns/1ps
`default_nettype none

module beat_fifo import store_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    beat_fifo_if.store  fifo
);

    beat_t mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;

    logic push_ok;
    logic pop_ok;

    assign push_ok = fifo.push && !fifo.full;
    assign pop_ok  = fifo.pop && !fifo.empty;

    assign fifo.full     = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign fifo.empty    = (count == '0);
    assign fifo.pop_data = mem[rd_ptr];

    // --------------------
    // Storage
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= fifo.push_data;
        end
    end

    // --------------------
    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // Depth is a power of two, pointers wrap naturally
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/beat_fifo_if.sv
// Push and pop sides of the data-beat FIFO.
// writer feeds beats in, reader drains them, store is the FIFO itself.

`timescale 1ns/1ps
`default_nettype none

interface beat_fifo_if import store_pkg::*; ();

    logic  push;
    beat_t push_data;
    logic  full;
    logic  pop;
    beat_t pop_data;
    logic  empty;

    modport writer (
        output push, push_data,
        input  full
    );

    modport reader (
        output pop,
        input  pop_data, empty
    );

    modport store (
        input  push, push_data, pop,
        output full, pop_data, empty
    );

endinterface

`default_nettype wire

//--- rtl/store_pkg.sv
// Shared widths, burst shape and types for the tile store datapath.
// Imported by every RTL block and by the testbench.

`default_nettype none

package store_pkg;

    // --------------------
    // Bus and grid widths
    localparam int ADDR_W = 64;
    localparam int LEN_W  = 8;
    localparam int GRID_W = 10;
    localparam int DATA_W = 128;

    // --------------------
    // Burst shape
    localparam int BURST_BEATS  = 7;
    localparam int BURST_LEN    = BURST_BEATS - 1;
    localparam int BURST_STRIDE = BURST_BEATS * (DATA_W / 8);
    localparam int BEAT_IDX_W   = $clog2(BURST_BEATS);

    // --------------------
    // Beat buffer
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [GRID_W-1:0]     grid_t;
    typedef logic [DATA_W-1:0]     beat_t;
    // Holds (2^GRID_W)^2 bursts
    typedef logic [2*GRID_W:0]     burst_cnt_t;

    // One-hot states of the address generator
    typedef enum logic [2:0] {
        GEN_IDLE = 3'b001,
        GEN_ADDR = 3'b010,
        GEN_SEND = 3'b100
    } gen_state_t;

endpackage

`default_nettype wire

//--- rtl/tile_store_top.sv
// Top level of the tile store.
// Joins the AW generator, the beat FIFO and the W/B drain. Data beats enter
// on in_valid/in_data; in_full warns the source that the FIFO is full.
// done pulses once the whole region has been acknowledged.

`timescale 1ns/1ps
`default_nettype none

module tile_store_top import store_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_pulse,
    input  addr_t            target_address,
    input  grid_t            w1,
    input  grid_t            h1,
    input  logic             in_valid,
    input  beat_t            in_data,
    output logic             in_full,
    output addr_t            m_axi_awaddr,
    output logic [LEN_W-1:0] m_axi_awlen,
    output logic             m_axi_awvalid,
    input  logic             m_axi_awready,
    output beat_t            m_axi_wdata,
    output logic             m_axi_wlast,
    output logic             m_axi_wvalid,
    input  logic             m_axi_wready,
    input  logic             m_axi_bvalid,
    output logic             m_axi_bready,
    output logic             done
);

    beat_fifo_if fifo_if ();

    // Source side of the FIFO
    assign fifo_if.push      = in_valid;
    assign fifo_if.push_data = in_data;
    assign in_full           = fifo_if.full;

    tile_waddr_gen u_waddr_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_pulse    (start_pulse),
        .target_address (target_address),
        .w1             (w1),
        .h1             (h1),
        .m_axi_awaddr   (m_axi_awaddr),
        .m_axi_awlen    (m_axi_awlen),
        .m_axi_awvalid  (m_axi_awvalid),
        .m_axi_awready  (m_axi_awready)
    );

    beat_fifo u_beat_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .fifo  (fifo_if.store)
    );

    tile_wdata_drain u_wdata_drain (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_pulse  (start_pulse),
        .w1           (w1),
        .h1           (h1),
        .fifo         (fifo_if.reader),
        .m_axi_wdata  (m_axi_wdata),
        .m_axi_wlast  (m_axi_wlast),
        .m_axi_wvalid (m_axi_wvalid),
        .m_axi_wready (m_axi_wready),
        .m_axi_bvalid (m_axi_bvalid),
        .m_axi_bready (m_axi_bready),
        .done         (done)
    );

endmodule

`default_nettype wire

//--- rtl/tile_waddr_gen.sv
// Write-address generator for a rectangular region of tiles.
// After start_pulse it walks x = 0..w1 within each row y = 0..h1 and issues
// one seven-beat AW burst per tile, stepping the address by BURST_STRIDE.
// A start_pulse is only taken while idle.

`timescale 1ns/1ps
`default_nettype none

module tile_waddr_gen import store_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_pulse,
    input  addr_t            target_address,
    input  grid_t            w1,
    input  grid_t            h1,
    output addr_t            m_axi_awaddr,
    output logic [LEN_W-1:0] m_axi_awlen,
    output logic             m_axi_awvalid,
    input  logic             m_axi_awready
);

    gen_state_t cstate;
    gen_state_t nstate;

    grid_t       x;
    // One bit wider so the row count can step past h1 = max
    logic [GRID_W:0] y;
    addr_t       address;
    logic        first_tile;
    logic        row_end;

    assign first_tile = (x == '0) && (y == '0);
    assign row_end    = (x == w1);

    assign m_axi_awaddr  = address;
    assign m_axi_awlen   = LEN_W'(BURST_LEN);
    assign m_axi_awvalid = (cstate == GEN_SEND);

    // --------------------
    // State register and next state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cstate <= GEN_IDLE;
        end else begin
            cstate <= nstate;
        end
    end

    always_comb begin
        nstate = cstate;
        case (cstate)
            GEN_IDLE: begin
                if (start_pulse) begin
                    nstate = GEN_ADDR;
                end
            end
            GEN_ADDR: begin
                // Row counter past the last row ends the region
                if (y > {1'b0, h1}) begin
                    nstate = GEN_IDLE;
                end else begin
                    nstate = GEN_SEND;
                end
            end
            GEN_SEND: begin
                if (m_axi_awready) begin
                    nstate = GEN_ADDR;
                end
            end
            default: nstate = GEN_IDLE;
        endcase
    end

    // --------------------
    // Grid walk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (cstate == GEN_IDLE) begin
            x <= '0;
            y <= '0;
        end else if (cstate == GEN_ADDR) begin
            if (row_end) begin
                x <= '0;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Burst address, base on the first tile of the region
    always_ff @(posedge clk) begin
        if (cstate == GEN_ADDR) begin
            address <= first_tile ? target_address : address + ADDR_W'(BURST_STRIDE);
        end
    end

endmodule

`default_nettype wire

//--- rtl/tile_wdata_drain.sv
// Write-data channel driver for the tile store.
// Moves beats from the FIFO into a one-beat output register, marks the
// last beat of each burst and counts write responses. done pulses one
// cycle after the response that completes the region.

`timescale 1ns/1ps
`default_nettype none

module tile_wdata_drain import store_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_pulse,
    input  grid_t      w1,
    input  grid_t      h1,
    beat_fifo_if.reader fifo,
    output beat_t      m_axi_wdata,
    output logic       m_axi_wlast,
    output logic       m_axi_wvalid,
    input  logic       m_axi_wready,
    input  logic       m_axi_bvalid,
    output logic       m_axi_bready,
    output logic       done
);

    logic [BEAT_IDX_W-1:0] beat_idx;
    logic                  burst_end;

    logic            busy;
    logic [GRID_W:0] w_tiles;
    logic [GRID_W:0] h_tiles;
    burst_cnt_t      total;
    burst_cnt_t      resp_cnt;
    logic            b_xfer;

    // --------------------
    // Write data path
    // Refill the register when it is empty or being taken this cycle
    assign fifo.pop  = !fifo.empty && (!m_axi_wvalid || m_axi_wready);
    assign burst_end = (beat_idx == BEAT_IDX_W'(BURST_LEN));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_axi_wvalid <= 1'b0;
            m_axi_wlast  <= 1'b0;
            beat_idx     <= '0;
        end else if (fifo.pop) begin
            m_axi_wvalid <= 1'b1;
            m_axi_wlast  <= burst_end;
            beat_idx     <= burst_end ? '0 : beat_idx + 1'b1;
        end else if (m_axi_wready) begin
            m_axi_wvalid <= 1'b0;
            m_axi_wlast  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo.pop) begin
            m_axi_wdata <= fifo.pop_data;
        end
    end

    // --------------------
    // Response counting
    assign m_axi_bready = 1'b1;
    assign b_xfer       = m_axi_bvalid && m_axi_bready;

    // Bursts in the region, (w1+1)*(h1+1)
    assign w_tiles = {1'b0, w1} + 1'b1;
    assign h_tiles = {1'b0, h1} + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            total    <= '0;
            resp_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                // A start seen mid-run is ignored, as in the generator
                if (start_pulse) begin
                    busy     <= 1'b1;
                    total    <= burst_cnt_t'(w_tiles) * burst_cnt_t'(h_tiles);
                    resp_cnt <= '0;
                end
            end else if (b_xfer) begin
                resp_cnt <= resp_cnt + burst_cnt_t'(1);
                if (resp_cnt + burst_cnt_t'(1) == total) begin
                    done <= 1'b1;
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_tile_store.sv
// Testbench for the tile store.
// Runs several regions with random grid limits, base addresses, data beats
// and AXI back-pressure. A small memory-side responder answers each burst,
// and the AW addresses and lengths, W beats, in_full and done are checked
// against a model.

`timescale 1ns/1ps
`default_nettype none

module tb_tile_store import store_pkg::*; ();

    localparam int unsigned SEED = 32'h7f8a341b;
    localparam int NUM_RUNS     = 6;
    localparam int RUN_LIMIT    = 5000;
    localparam int QUIET_CYCLES = 12;
    localparam int FILL_HOLD    = 40;

    logic             clk;
    logic             rst_n;
    logic             start_pulse;
    addr_t            target_address;
    grid_t            w1;
    grid_t            h1;
    logic             in_valid;
    beat_t            in_data;
    logic             in_full;
    addr_t            m_axi_awaddr;
    logic [LEN_W-1:0] m_axi_awlen;
    logic             m_axi_awvalid;
    logic             m_axi_awready;
    beat_t            m_axi_wdata;
    logic             m_axi_wlast;
    logic             m_axi_wvalid;
    logic             m_axi_wready;
    logic             m_axi_bvalid;
    logic             m_axi_bready;
    logic             done;

    // Expected traffic of the current region
    addr_t      addr_q[$];
    beat_t      beat_q[$];
    int         total;
    int         beats_due;
    int         push_cnt;
    int         aw_cnt;
    int         w_cnt;
    burst_cnt_t b_cnt;
    int         done_cnt;
    int         b_wait;
    int         hold_left;
    logic       b_taken;
    logic       start_req;
    logic       mid_start_sent;
    logic       saw_full;

    tile_store_top u_dut (.*);

    bind tile_store_top tile_store_asserts u_asserts (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // Failure reporting
    task automatic report_mismatch(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped after a failed check");
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("awaddr %h, expected %h", got, exp));
        end
    endtask

    task automatic check_len(input logic [LEN_W-1:0] got, input logic [LEN_W-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("awlen %0d, expected %0d", got, exp));
        end
    endtask

    task automatic check_beat(input beat_t got, input logic got_last,
                              input beat_t exp, input logic exp_last);
        if (got !== exp || got_last !== exp_last) begin
            report_mismatch($sformatf("wdata %h wlast %b, expected %h wlast %b",
                                      got, got_last, exp, exp_last));
        end
    endtask

    task automatic check_done(input burst_cnt_t got, input burst_cnt_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("done after %0d responses, expected %0d", got, exp));
        end
    endtask

    task automatic check_full(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("in_full %b, expected %b", got, exp));
        end
    endtask

    // --------------------
    // One clock cycle that observes the last rising edge and drives the next one
    task automatic drive_cycle();
        int owed;
        int occ;
        @(negedge clk);
        if (u_dut.u_asserts.fail_cnt != 0) begin
            abort_run("A bound assertion on the AXI or FIFO signals failed");
        end else if (m_axi_awvalid && addr_q.size() == 0) begin
            abort_run("awvalid rose with no burst left in the region");
        end
        if (done) begin
            done_cnt++;
            if (done_cnt > 1) begin
                abort_run("done pulsed more than once in one region");
            end
            check_done(b_cnt, burst_cnt_t'(total));
        end
        // FIFO holds what was pushed minus what sits in or left the W register
        occ = push_cnt - w_cnt - int'(m_axi_wvalid);
        check_full(in_full, occ == FIFO_DEPTH);
        saw_full = saw_full | in_full;

        start_pulse = 1'b0;
        if (start_req) begin
            start_pulse = 1'b1;
            start_req   = 1'b0;
        end else if (!mid_start_sent && m_axi_awvalid && (aw_cnt > 0 || total == 1)) begin
            // Generator is busy so this start must be ignored
            start_pulse    = 1'b1;
            mid_start_sent = 1'b1;
        end

        if (hold_left > 0) begin
            m_axi_wready = 1'b0;
            hold_left--;
        end else begin
            m_axi_wready = ($urandom_range(3) != 0);
        end
        m_axi_awready = ($urandom_range(2) != 0);

        in_valid = 1'b0;
        if (push_cnt < beats_due && !in_full && $urandom_range(4) != 0) begin
            in_valid = 1'b1;
            in_data  = {$urandom(), $urandom(), $urandom(), $urandom()};
            beat_q.push_back(in_data);
            push_cnt++;
        end

        // Responder answers a burst once both its address and last beat are in
        if (b_taken) begin
            m_axi_bvalid = 1'b0;
            b_wait       = $urandom_range(3);
        end
        owed = ((aw_cnt < w_cnt / BURST_BEATS) ? aw_cnt : w_cnt / BURST_BEATS) - int'(b_cnt);
        if (!m_axi_bvalid && owed > 0) begin
            if (b_wait == 0) begin
                m_axi_bvalid = 1'b1;
            end else begin
                b_wait--;
            end
        end
        b_taken = m_axi_bvalid && m_axi_bready;
        if (b_taken) begin
            b_cnt++;
        end

        if (m_axi_awvalid && m_axi_awready) begin
            check_addr(m_axi_awaddr, addr_q.pop_front());
            check_len(m_axi_awlen, LEN_W'(BURST_BEATS - 1));
            aw_cnt++;
        end
        if (m_axi_wvalid && m_axi_wready) begin
            if (beat_q.size() == 0) begin
                abort_run("A W beat went out with no pushed beat left to match");
            end else begin
                check_beat(m_axi_wdata, m_axi_wlast, beat_q.pop_front(),
                           (w_cnt % BURST_BEATS) == BURST_LEN);
                w_cnt++;
            end
        end
    endtask

    // New grid limits and base with the address list they imply
    task automatic start_region(input int run);
        if (run == 0) begin
            // At least four tiles so the FIFO overfills while wready is low
            w1        = grid_t'($urandom_range(3, 1));
            h1        = grid_t'($urandom_range(3, 1));
            hold_left = FILL_HOLD;
        end else begin
            w1        = grid_t'($urandom_range(3));
            h1        = grid_t'($urandom_range(3));
            hold_left = 0;
        end
        target_address = {$urandom(), $urandom()} & ~addr_t'(15);
        total          = (int'(w1) + 1) * (int'(h1) + 1);
        beats_due      = total * BURST_BEATS;
        for (int k = 0; k < total; k++) begin
            addr_q.push_back(target_address + addr_t'(k) * addr_t'(BURST_STRIDE));
        end
        push_cnt       = 0;
        aw_cnt         = 0;
        w_cnt          = 0;
        b_cnt          = '0;
        done_cnt       = 0;
        b_taken        = 1'b0;
        b_wait         = $urandom_range(3);
        mid_start_sent = 1'b0;
        start_req      = 1'b1;
    endtask

    initial begin
        int cycles;
        void'($urandom(SEED));
        rst_n          = 1'b0;
        start_pulse    = 1'b0;
        target_address = '0;
        w1             = '0;
        h1             = '0;
        in_valid       = 1'b0;
        in_data        = '0;
        m_axi_awready  = 1'b0;
        m_axi_wready   = 1'b0;
        m_axi_bvalid   = 1'b0;
        total          = 0;
        saw_full       = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int run = 0; run < NUM_RUNS; run++) begin
            start_region(run);
            cycles = 0;
            while (done_cnt == 0) begin
                if (cycles >= RUN_LIMIT) begin
                    abort_run($sformatf("Timeout waiting for done in region %0d", run));
                end else begin
                    drive_cycle();
                    cycles++;
                end
            end
            // Nothing may follow done
            repeat (QUIET_CYCLES) drive_cycle();
        end

        if (!saw_full) begin
            abort_run("in_full never rose while wready was held low");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/tile_store_asserts.sv
// Concurrent checks on the AXI write channels and the beat FIFO input.
// Bound to tile_store_top; each failing property raises $error.

`timescale 1ns/1ps
`default_nettype none

module tile_store_asserts import store_pkg::*; (
    input logic             clk,
    input logic             rst_n,
    input addr_t            m_axi_awaddr,
    input logic [LEN_W-1:0] m_axi_awlen,
    input logic             m_axi_awvalid,
    input logic             m_axi_awready,
    input beat_t            m_axi_wdata,
    input logic             m_axi_wlast,
    input logic             m_axi_wvalid,
    input logic             m_axi_wready,
    input logic             in_valid,
    input logic             in_full
);

    // Number of failed properties, polled by the testbench
    int unsigned fail_cnt = 0;

    // --------------------
    // AW channel
    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
    else begin
        $error("awvalid dropped or awaddr changed before awready");
        fail_cnt++;
    end

    a_aw_len: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_awlen == LEN_W'(BURST_LEN))
    else begin
        $error("awlen differs from the seven-beat burst length");
        fail_cnt++;
    end

    // --------------------
    // W channel and FIFO input
    a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_wvalid && !m_axi_wready |=>
            m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wlast))
    else begin
        $error("wvalid dropped or W payload changed before wready");
        fail_cnt++;
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_valid && in_full))
    else begin
        $error("beat pushed while the FIFO was full");
        fail_cnt++;
    end

endmodule

`default_nettype wire
